// ==== common/des_pkg.sv ====
package des_pkg;

    typedef logic [63:0] des_block_t;
    typedef logic [31:0] des_half_t;
    typedef logic [63:0] des_key_t;
    typedef logic [55:0] des_cd_t;
    typedef logic [47:0] des_round_key_t;
    typedef logic [3:0]  des_round_t;

    localparam int NUM_ROUNDS = 16;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ROUND,
        DONE
    } des_state_e;

    typedef enum logic [7:0] {
        KEY_HI    = 8'h00,
        KEY_LO    = 8'h04,
        DATA_HI   = 8'h08,
        DATA_LO   = 8'h0C,
        CTRL      = 8'h10,
        STATUS    = 8'h14,
        RESULT_HI = 8'h18,
        RESULT_LO = 8'h1C
    } apb_reg_e;

    // tables use DES numbering, bit 1 is the msb
    localparam int IP_TBL [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int FP_TBL [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
    };

    localparam int PC1_TBL [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };

    localparam int PC2_TBL [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
        26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    localparam int E_TBL [48] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam int P_TBL [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };

    localparam int SHIFT_TBL [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // index is row * 16 + column
    localparam int SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    function automatic des_block_t ip_perm(input des_block_t din);
        des_block_t dout;
        for (int i = 0; i < 64; i++)
        begin
            dout[63 - i] = din[64 - IP_TBL[i]];
        end
        return dout;
    endfunction

    function automatic des_block_t fp_perm(input des_block_t din);
        des_block_t dout;
        for (int i = 0; i < 64; i++)
        begin
            dout[63 - i] = din[64 - FP_TBL[i]];
        end
        return dout;
    endfunction

    // drops the parity bits
    function automatic des_cd_t pc1_perm(input des_key_t din);
        des_cd_t dout;
        for (int i = 0; i < 56; i++)
        begin
            dout[55 - i] = din[64 - PC1_TBL[i]];
        end
        return dout;
    endfunction

    function automatic des_round_key_t pc2_perm(input des_cd_t din);
        des_round_key_t dout;
        for (int i = 0; i < 48; i++)
        begin
            dout[47 - i] = din[56 - PC2_TBL[i]];
        end
        return dout;
    endfunction

    function automatic des_round_key_t expand(input des_half_t din);
        des_round_key_t dout;
        for (int i = 0; i < 48; i++)
        begin
            dout[47 - i] = din[32 - E_TBL[i]];
        end
        return dout;
    endfunction

    function automatic des_half_t p_perm(input des_half_t din);
        des_half_t dout;
        for (int i = 0; i < 32; i++)
        begin
            dout[31 - i] = din[32 - P_TBL[i]];
        end
        return dout;
    endfunction

    // outer bits pick the row, inner four the column
    function automatic logic [3:0] sbox_lookup(input int box, input logic [5:0] six);
        return 4'(SBOX[box][{six[5], six[0], six[4:1]}]);
    endfunction

    function automatic logic [1:0] shift_amount(input des_round_t round);
        return 2'(SHIFT_TBL[round]);
    endfunction

endpackage

// ==== des_core/des_key_sched.sv ====
`timescale 1ns/1ps

module des_key_sched (
    input  logic                    clk,
    input  logic                    reset,
    input  des_pkg::des_key_t       key,
    input  logic                    load,
    input  logic                    step,
    input  des_pkg::des_round_t     round,
    output des_pkg::des_round_key_t round_key
);
    import des_pkg::*;

    des_cd_t     cd_q;
    des_cd_t     cd_rot;
    logic [27:0] c_half, d_half;

    assign c_half = cd_q[55:28];
    assign d_half = cd_q[27:0];

    // C and D rotate separately
    always_comb
    begin
        if (shift_amount(round) == 2'd2)
        begin
            cd_rot = {c_half[25:0], c_half[27:26], d_half[25:0], d_half[27:26]};
        end
        else
        begin
            cd_rot = {c_half[26:0], c_half[27], d_half[26:0], d_half[27]};
        end
    end

    // key for the current round, ready in the step cycle
    assign round_key = pc2_perm(cd_rot);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cd_q <= '0;
        end
        else if (load)
        begin
            cd_q <= pc1_perm(key);
        end
        else if (step)
        begin
            cd_q <= cd_rot;
        end
    end

endmodule

// ==== des_core/des_round.sv ====
`timescale 1ns/1ps

module des_round (
    input  des_pkg::des_half_t      right,
    input  des_pkg::des_round_key_t round_key,
    output des_pkg::des_half_t      f_out
);
    import des_pkg::*;

    des_round_key_t mixed;
    des_half_t      sbox_out;

    assign mixed = expand(right) ^ round_key;

    // S1 takes the top six bits
    always_comb
    begin
        for (int b = 0; b < 8; b++)
        begin
            sbox_out[31 - 4 * b -: 4] = sbox_lookup(b, mixed[47 - 6 * b -: 6]);
        end
    end

    assign f_out = p_perm(sbox_out);

endmodule

// ==== des_core/des_state.sv ====
`timescale 1ns/1ps

module des_state (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  logic                step,
    input  des_pkg::des_block_t block_in,
    input  des_pkg::des_half_t  f_out,
    output des_pkg::des_half_t  right,
    output des_pkg::des_block_t result
);
    import des_pkg::*;

    des_half_t  l_q, r_q;
    des_block_t ip_blk;

    assign ip_blk = ip_perm(block_in);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            l_q <= '0;
            r_q <= '0;
        end
        else if (load)
        begin
            l_q <= ip_blk[63:32];
            r_q <= ip_blk[31:0];
        end
        else if (step)
        begin
            // feistel swap
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
    end

    assign right = r_q;

    // halves swapped before the final permutation
    assign result = fp_perm({r_q, l_q});

endmodule

// ==== hdl/des_apb_ctrl.sv ====
`timescale 1ns/1ps

module des_apb_ctrl #(
    parameter int addr_width = 5
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [addr_width-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  des_pkg::des_half_t      pwdata,
    output des_pkg::des_half_t      prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  des_pkg::des_block_t     result,
    output des_pkg::des_key_t       key,
    output des_pkg::des_block_t     block_in,
    output logic                    load,
    output logic                    step,
    output des_pkg::des_round_t     round
);
    import des_pkg::*;

    des_state_e state;
    apb_reg_e   offset;
    des_half_t  key_hi, key_lo, data_hi, data_lo, result_hi, result_lo;
    des_half_t  rdata;
    logic       wr_en, rd_en, wr_ok, reg_err, start_wr;
    logic       start_q, busy, done;

    assign offset = apb_reg_e'(8'(paddr));
    assign wr_en  = psel && penable && pwrite;
    assign rd_en  = psel && penable && !pwrite;

    // register decode, refuses writes to operands while busy
    always_comb
    begin
        rdata   = '0;
        reg_err = 1'b0;
        case (offset)
            KEY_HI:    begin rdata = key_hi;    reg_err = pwrite && busy; end
            KEY_LO:    begin rdata = key_lo;    reg_err = pwrite && busy; end
            DATA_HI:   begin rdata = data_hi;   reg_err = pwrite && busy; end
            DATA_LO:   begin rdata = data_lo;   reg_err = pwrite && busy; end
            CTRL:      reg_err = pwrite && busy;
            STATUS:    begin rdata = {30'd0, done, busy}; reg_err = pwrite; end
            RESULT_HI: begin rdata = result_hi; reg_err = pwrite; end
            RESULT_LO: begin rdata = result_lo; reg_err = pwrite; end
            default:   reg_err = 1'b1;
        endcase
    end

    assign prdata   = rd_en ? rdata : '0;
    assign pslverr  = psel && penable && reg_err;
    assign pready   = 1'b1;
    assign wr_ok    = wr_en && !reg_err;
    assign start_wr = wr_ok && (offset == CTRL) && pwdata[0];

    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            case (offset)
                KEY_HI:  key_hi  <= pwdata;
                KEY_LO:  key_lo  <= pwdata;
                DATA_HI: data_hi <= pwdata;
                DATA_LO: data_lo <= pwdata;
                default: ;
            endcase
        end
    end

    assign key      = {key_hi, key_lo};
    assign block_in = {data_hi, data_lo};
    assign load     = (state == LOAD);
    assign step     = (state == ROUND);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= IDLE;
            round   <= '0;
            start_q <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            if (start_wr)
            begin
                start_q <= 1'b1;
                busy    <= 1'b1;
                done    <= 1'b0;
            end
            case (state)
                IDLE, DONE:
                begin
                    if (start_q)
                    begin
                        state   <= LOAD;
                        start_q <= 1'b0;
                    end
                end
                LOAD:
                begin
                    state <= ROUND;
                    round <= '0;
                end
                ROUND:
                begin
                    round <= round + 1'b1;
                    if (round == des_round_t'(NUM_ROUNDS - 1))
                    begin
                        state <= DONE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // last step lands on the edge into DONE, so sample from the DONE cycle on
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_hi <= '0;
            result_lo <= '0;
        end
        else if (state == DONE)
        begin
            result_hi <= result[63:32];
            result_lo <= result[31:0];
        end
    end

endmodule

// ==== hdl/des_top.sv ====
`timescale 1ns/1ps

module des_top #(
    parameter int addr_width = 5
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [addr_width-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  des_pkg::des_half_t      pwdata,
    output des_pkg::des_half_t      prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import des_pkg::*;

    des_key_t       key;
    des_block_t     block_in;
    des_block_t     result;
    des_round_t     round;
    des_round_key_t round_key;
    des_half_t      right;
    des_half_t      f_out;
    logic           load;
    logic           step;

    des_apb_ctrl #(
        .addr_width (addr_width)
    ) u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .result   (result),
        .key      (key),
        .block_in (block_in),
        .load     (load),
        .step     (step),
        .round    (round)
    );

    des_key_sched u_key_sched (
        .clk       (clk),
        .reset     (reset),
        .key       (key),
        .load      (load),
        .step      (step),
        .round     (round),
        .round_key (round_key)
    );

    des_round u_round (
        .right     (right),
        .round_key (round_key),
        .f_out     (f_out)
    );

    des_state u_state (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .step     (step),
        .block_in (block_in),
        .f_out    (f_out),
        .right    (right),
        .result   (result)
    );

endmodule

// ==== bench/des_tb_clock.sv ====
`timescale 1ns/1ps

module des_tb_clock (
    output logic clk
);

    // 4 ns period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

endmodule

// ==== bench/des_tb.sv ====
`timescale 1ns/1ps

module des_tb;
    import des_pkg::*;

    localparam int addr_width = 5;
    localparam int max_cycles = 100;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    des_half_t             pwdata;
    des_half_t             prdata;
    logic                  pready;
    logic                  pslverr;

    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    logic [31:0] seed;
    logic [63:0] key_q[$];
    logic [63:0] pt_q[$];
    logic [63:0] exp_q[$];

    des_tb_clock u_clock (
        .clk (clk)
    );

    des_top #(
        .addr_width (addr_width)
    ) u_des_top (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s read %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // two-cycle transfer sampled mid-way through the access phase
    task automatic apb_access(input logic [7:0] offs, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = offs[addr_width-1:0];
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        compare_value("pready", 64'(pready), 64'd1);
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] offs, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused;
        apb_access(offs, 1'b1, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] offs, output logic [31:0] rdata,
                            output logic err);
        apb_access(offs, 1'b0, 32'd0, rdata, err);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before)
        begin
            pass_count++;
            $display("%s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("%s: fail", name);
        end
    endtask

    // lines starting with # are skipped by the scan
    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [63:0] k;
        logic [63:0] p;
        logic [63:0] c;
        fd = $fopen("bench/des_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file bench/des_patterns.txt");
            error_count++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%h %h %h", k, p, c) == 3)
                begin
                    key_q.push_back(k);
                    pt_q.push_back(p);
                    exp_q.push_back(c);
                end
            end
            $fclose(fd);
        end
        if (key_q.size() == 0)
        begin
            $display("no test patterns were read");
            error_count++;
        end
    endtask

    task automatic check_reset_values();
        logic [31:0] d;
        logic        e;
        int          errs;
        errs = error_count;
        apb_read(STATUS, d, e);
        compare_value("STATUS", 64'(d), 64'd0);
        compare_value("STATUS pslverr", 64'(e), 64'd0);
        apb_read(RESULT_HI, d, e);
        compare_value("RESULT_HI", 64'(d), 64'd0);
        apb_read(RESULT_LO, d, e);
        compare_value("RESULT_LO", 64'(d), 64'd0);
        report_test("reset values", errs);
    endtask

    task automatic run_pattern(input int idx, input logic [63:0] key, input logic [63:0] pt,
                               input logic [63:0] exp, input logic reuse_key,
                               input logic poke_busy);
        logic [31:0] st;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        e;
        int          errs;
        int          start_cycle;
        logic        seen_done;
        errs = error_count;
        if (!reuse_key)
        begin
            apb_write(KEY_HI, key[63:32], e);
            compare_value("KEY_HI pslverr", 64'(e), 64'd0);
            apb_write(KEY_LO, key[31:0], e);
            compare_value("KEY_LO pslverr", 64'(e), 64'd0);
        end
        apb_write(DATA_HI, pt[63:32], e);
        compare_value("DATA_HI pslverr", 64'(e), 64'd0);
        apb_write(DATA_LO, pt[31:0], e);
        compare_value("DATA_LO pslverr", 64'(e), 64'd0);
        apb_write(CTRL, 32'd1, e);
        compare_value("CTRL pslverr", 64'(e), 64'd0);
        apb_read(STATUS, st, e);
        compare_value("STATUS after start", 64'(st), 64'd1);
        if (poke_busy)
        begin
            // operand writes must bounce while the engine runs
            seed = lcg_next(seed);
            apb_write(KEY_HI, seed, e);
            compare_value("KEY_HI pslverr while busy", 64'(e), 64'd1);
            seed = lcg_next(seed);
            apb_write(DATA_LO, seed, e);
            compare_value("DATA_LO pslverr while busy", 64'(e), 64'd1);
        end
        start_cycle = cycle_count;
        seen_done = 1'b0;
        while (!seen_done && (cycle_count - start_cycle) < max_cycles)
        begin
            apb_read(STATUS, st, e);
            if (st[1])
            begin
                seen_done = 1'b1;
            end
            else
            begin
                compare_value("STATUS while busy", 64'(st), 64'd1);
            end
        end
        if (!seen_done)
        begin
            $display("pattern %0d: done never rose within %0d clock cycles", idx, max_cycles);
            error_count++;
        end
        else
        begin
            compare_value("STATUS when done", 64'(st), 64'd2);
            apb_read(RESULT_HI, hi, e);
            apb_read(RESULT_LO, lo, e);
            compare_value("RESULT", {hi, lo}, exp);
            if (poke_busy)
            begin
                apb_read(KEY_HI, hi, e);
                compare_value("KEY_HI after refused write", 64'(hi), 64'(key[63:32]));
                apb_read(DATA_LO, lo, e);
                compare_value("DATA_LO after refused write", 64'(lo), 64'(pt[31:0]));
            end
        end
        report_test($sformatf("pattern %0d key %h pt %h%s", idx, key, pt,
                              reuse_key ? " (key reused)" : ""), errs);
    endtask

    task automatic check_error_accesses(input logic [63:0] last);
        logic [31:0] hi;
        logic [31:0] lo;
        logic        e;
        int          errs;
        errs = error_count;
        // 0x1E is unaligned and maps to no register
        apb_read(8'h1E, hi, e);
        compare_value("unmapped read pslverr", 64'(e), 64'd1);
        seed = lcg_next(seed);
        apb_write(8'h1E, seed, e);
        compare_value("unmapped write pslverr", 64'(e), 64'd1);
        seed = lcg_next(seed);
        apb_write(RESULT_HI, seed, e);
        compare_value("RESULT_HI write pslverr", 64'(e), 64'd1);
        apb_read(RESULT_HI, hi, e);
        apb_read(RESULT_LO, lo, e);
        compare_value("RESULT after bad accesses", {hi, lo}, last);
        report_test("error accesses", errs);
    endtask

    initial
    begin
        logic reuse;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hd6a5;
        load_patterns();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_reset_values();
        for (int i = 0; i < key_q.size(); i++)
        begin
            reuse = (i > 0) && (key_q[i] == key_q[i - 1]);
            run_pattern(i, key_q[i], pt_q[i], exp_q[i], reuse, (i % 2) == 0);
        end
        if (exp_q.size() > 0)
        begin
            check_error_accesses(exp_q[exp_q.size() - 1]);
        end

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== bench/des_patterns.txt ====
# key plaintext ciphertext, 64-bit hex each
# equal keys on adjacent lines reuse the loaded key
133457799BBCDFF1 0123456789ABCDEF 85E813540F0AB405
0E329232EA6D0D73 8787878787878787 0000000000000000
0123456789ABCDEF 4E6F772069732074 3FA40E8A984D4815
0123456789ABCDEF 1111111111111111 17668DFC7292532D
0000000000000000 0000000000000000 8CA64DE9C1B123A7
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7359B2163E4EDC58
1111111111111111 0123456789ABCDEF 8A5AE1F81AB8F2DD
FEDCBA9876543210 0123456789ABCDEF ED39D950FA74BCC4

// ==== verilog.f ====
common/des_pkg.sv
des_core/des_key_sched.sv
des_core/des_round.sv
des_core/des_state.sv
hdl/des_apb_ctrl.sv
hdl/des_top.sv
bench/des_tb_clock.sv
bench/des_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module des_tb -o des_sim
./obj_dir/des_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
